//--- common/opc_params.svh
/*
 * Constants of the packet output path: word size, preamble bytes and the
 * inter-frame gap. Include this wherever one of these values is needed.
 */

`ifndef OPC_PARAMS_SVH
`define OPC_PARAMS_SVH

////////////////////////////////////////////////////////////////////////
// input word
////////////////////////////////////////////////////////////////////////

`define OPC_WORD_BYTES      16      // payload bytes per 134-bit word

////////////////////////////////////////////////////////////////////////
// ethernet framing
////////////////////////////////////////////////////////////////////////

`define OPC_PREAMBLE_LEN    8       // seven preamble bytes plus the sfd
`define OPC_PREAMBLE_BYTE   8'h55
`define OPC_SFD_BYTE        8'hD5

// idle cycles held after the last byte of a frame
`define OPC_IFG_CYCLES      12

`endif

//--- common/opc_word_pkg.sv
/*
 * Types of the 134-bit input word: position flag, invalid byte count
 * and the 128-bit data field. Imported by the input side and serializer.
 */

`include "opc_params.svh"

package opc_word_pkg;

    // frame position of a word, bit 0 marks first and bit 1 marks last
    typedef enum logic [1:0] {
        OPC_FLAG_MIDDLE = 2'b00,
        OPC_FLAG_FIRST  = 2'b01,
        OPC_FLAG_LAST   = 2'b10,
        OPC_FLAG_SINGLE = 2'b11    // first and last at once
    } opc_flag_t;

    typedef logic [3:0] opc_inval_t;      // invalid bytes at the tail
    typedef logic [3:0] opc_byte_idx_t;   // byte 0 is the most significant

    // flag in [133:132], invalid count in [131:128], data in [127:0]
    typedef struct packed {
        opc_flag_t                       flag;
        opc_inval_t                      inval;
        logic [`OPC_WORD_BYTES*8-1:0]    data;
    } opc_word_t;

endpackage

//--- common/opc_gmii_pkg.sv
/*
 * Types of the GMII side: the 9-bit output byte with its frame marker
 * and the framer state reported to the outside.
 */

package opc_gmii_pkg;

    // marker in bit 8 flags the first preamble byte and the last data byte
    typedef struct packed {
        logic          marker;
        logic [7:0]    data;
    } opc_gmii_byte_t;

    typedef enum logic [2:0] {
        OPC_ST_IDLE     = 3'd0,
        OPC_ST_PREAMBLE = 3'd1,
        OPC_ST_DATA     = 3'd2,
        OPC_ST_GAP      = 3'd3
    } opc_state_t;

endpackage

//--- word_buffer/opc_word_buffer.sv
/*
 * Two-slot word store in front of the serializer. Words leave in write
 * order; the read request stays high while a slot is free.
 */

`timescale 1ns/1ns

module opc_word_buffer
    import opc_word_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,

    input  opc_word_t    i_pkt_data,
    input  logic         i_pkt_data_wr,    // one-cycle write strobe
    input  logic         i_pop,            // head is consumed on this edge

    output opc_word_t    o_head,
    output logic         o_head_valid,
    output logic         o_pkt_rd_req,
    output logic         o_pkt_tx_finish
);

    opc_word_t    slot_q [2];
    logic [1:0]   valid_q;
    logic         wr_ptr_q;    // next slot to fill
    logic         rd_ptr_q;    // oldest stored word
    logic         do_wr;
    logic         do_pop;

    ////////////////////////////////////////////////////////////////////
    // write and pop control
    ////////////////////////////////////////////////////////////////////

    // a write into a full buffer is dropped
    assign do_wr  = i_pkt_data_wr && !valid_q[wr_ptr_q];
    assign do_pop = i_pop && valid_q[rd_ptr_q];

    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            slot_q[wr_ptr_q] <= i_pkt_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q  <= 2'b00;
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
        end else begin
            // slots differ whenever both fire, so the two updates never collide
            if (do_wr) begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q          <= ~wr_ptr_q;
            end
            if (do_pop) begin
                valid_q[rd_ptr_q] <= 1'b0;
                rd_ptr_q          <= ~rd_ptr_q;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////

    assign o_head       = slot_q[rd_ptr_q];
    assign o_head_valid = valid_q[rd_ptr_q];
    assign o_pkt_rd_req = !(valid_q[0] && valid_q[1]);   // a slot is free

    // flag bit 1 covers both last and single words
    assign o_pkt_tx_finish = i_pkt_data_wr && i_pkt_data.flag[1];

    ////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////

    // the upstream reader only writes after seeing the request
    a_no_write_when_full : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_pkt_data_wr |-> o_pkt_rd_req
    ) else $error("word written while both slots are full");

    // the serializer only pops a word it was shown
    a_no_pop_when_empty : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> o_head_valid
    ) else $error("pop with no word stored");

endmodule

//--- byte_serializer/opc_byte_serializer.sv
/*
 * Walks the bytes of the head word, most significant first. The last
 * word of a packet is cut short by its invalid count. The word is popped
 * on the take of its last valid byte.
 */

`timescale 1ns/1ns

`include "opc_params.svh"

module opc_byte_serializer
    import opc_word_pkg::*;
(
    input  logic          i_clk,
    input  logic          i_rst_n,

    input  opc_word_t     i_head,
    input  logic          i_head_valid,
    input  logic          i_byte_take,     // one-cycle pulse from the framer

    output logic [7:0]    o_byte,
    output logic          o_byte_valid,
    output logic          o_byte_sof,
    output logic          o_byte_eof,
    output logic          o_pop
);

    localparam opc_byte_idx_t FULL_LAST = opc_byte_idx_t'(`OPC_WORD_BYTES - 1);

    opc_byte_idx_t    idx_q;       // byte of the head currently offered
    opc_byte_idx_t    last_idx;
    logic             is_first;
    logic             is_last;
    logic             at_last;

    ////////////////////////////////////////////////////////////////////
    // byte selection
    ////////////////////////////////////////////////////////////////////

    assign is_first = i_head.flag[0];   // first or single
    assign is_last  = i_head.flag[1];   // last or single

    // inval of 15 leaves byte 0 as the only valid byte
    assign last_idx = is_last ? (FULL_LAST - i_head.inval) : FULL_LAST;
    assign at_last  = (idx_q == last_idx);

    assign o_byte       = i_head.data[(int'(FULL_LAST) - int'(idx_q)) * 8 +: 8];
    assign o_byte_valid = i_head_valid;
    assign o_byte_sof   = i_head_valid && is_first && (idx_q == '0);
    assign o_byte_eof   = i_head_valid && is_last && at_last;

    // word leaves the buffer on the same edge as its last byte
    assign o_pop = i_byte_take && at_last;

    ////////////////////////////////////////////////////////////////////
    // byte index
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idx_q <= '0;
        end else if (i_byte_take) begin
            if (at_last) begin
                idx_q <= '0;   // next word starts from its top byte
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    // the framer takes only while a byte is on offer
    a_take_needs_byte : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_byte_take |-> o_byte_valid
    ) else $error("byte taken with no head word");

endmodule

//--- gmii_framer/opc_gmii_framer.sv
/*
 * GMII frame generator. Sends the preamble and sfd, forwards data bytes
 * from the serializer and holds a fixed gap after each frame. All outputs
 * are registered; o_opc_state gives the state that produced the byte.
 */

`timescale 1ns/1ns

`include "opc_params.svh"

module opc_gmii_framer
    import opc_gmii_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,

    input  logic [7:0]        i_byte,
    input  logic              i_byte_valid,
    input  logic              i_byte_sof,
    input  logic              i_byte_eof,
    output logic              o_byte_take,

    output opc_gmii_byte_t    o_gmii_data,
    output logic              o_gmii_wr,
    output opc_state_t        o_opc_state
);

    localparam logic [3:0] PRE_LAST = 4'(`OPC_PREAMBLE_LEN - 1);
    localparam logic [3:0] IFG_LAST = 4'(`OPC_IFG_CYCLES - 1);

    opc_state_t    state_q;
    logic [3:0]    cnt_q;     // preamble byte or gap cycle count

    // a byte is consumed in every data cycle that has one
    assign o_byte_take = (state_q == OPC_ST_DATA) && i_byte_valid;

    ////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= OPC_ST_IDLE;
            cnt_q       <= '0;
            o_gmii_wr   <= 1'b0;
            o_opc_state <= OPC_ST_IDLE;
        end else begin
            o_opc_state <= state_q;   // aligned with the byte below
            case (state_q)
                OPC_ST_IDLE: begin
                    o_gmii_wr <= 1'b0;
                    cnt_q     <= '0;
                    if (i_byte_sof) begin
                        state_q <= OPC_ST_PREAMBLE;
                    end
                end
                OPC_ST_PREAMBLE: begin
                    o_gmii_wr <= 1'b1;
                    if (cnt_q == PRE_LAST) begin
                        cnt_q   <= '0;
                        state_q <= OPC_ST_DATA;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                OPC_ST_DATA: begin
                    o_gmii_wr <= i_byte_valid;   // stall keeps the frame open
                    if (i_byte_valid && i_byte_eof) begin
                        state_q <= OPC_ST_GAP;
                    end
                end
                OPC_ST_GAP: begin
                    o_gmii_wr <= 1'b0;
                    if (cnt_q == IFG_LAST) begin
                        cnt_q   <= '0;
                        state_q <= OPC_ST_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    o_gmii_wr <= 1'b0;
                    cnt_q     <= '0;
                    state_q   <= OPC_ST_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // output byte
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (state_q == OPC_ST_PREAMBLE) begin
            o_gmii_data.marker <= (cnt_q == '0);   // frame start
            o_gmii_data.data   <= (cnt_q == PRE_LAST) ? `OPC_SFD_BYTE
                                                      : `OPC_PREAMBLE_BYTE;
        end else if (o_byte_take) begin
            o_gmii_data <= '{marker: i_byte_eof, data: i_byte};
        end
    end

endmodule

//--- src/output_control.sv
/*
 * Output control for one network port. Takes 134-bit packet words and
 * sends them as GMII bytes with preamble, frame marker and gap.
 */

`timescale 1ns/1ns

module output_control
    import opc_word_pkg::*;
    import opc_gmii_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,

    input  opc_word_t         i_pkt_data,
    input  logic              i_pkt_data_wr,
    output logic              o_pkt_rd_req,
    output logic              o_pkt_tx_finish,

    output opc_gmii_byte_t    o_gmii_data,
    output logic              o_gmii_wr,
    output opc_state_t        o_opc_state
);

    opc_word_t      head;
    logic           head_valid;
    logic           pop;

    logic [7:0]     ser_byte;
    logic           ser_byte_valid;
    logic           ser_byte_sof;
    logic           ser_byte_eof;
    logic           byte_take;

    opc_word_buffer i_opc_word_buffer (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_pkt_data      (i_pkt_data),
        .i_pkt_data_wr   (i_pkt_data_wr),
        .i_pop           (pop),
        .o_head          (head),
        .o_head_valid    (head_valid),
        .o_pkt_rd_req    (o_pkt_rd_req),
        .o_pkt_tx_finish (o_pkt_tx_finish)
    );

    opc_byte_serializer i_opc_byte_serializer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_head       (head),
        .i_head_valid (head_valid),
        .i_byte_take  (byte_take),
        .o_byte       (ser_byte),
        .o_byte_valid (ser_byte_valid),
        .o_byte_sof   (ser_byte_sof),
        .o_byte_eof   (ser_byte_eof),
        .o_pop        (pop)
    );

    opc_gmii_framer i_opc_gmii_framer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_byte       (ser_byte),
        .i_byte_valid (ser_byte_valid),
        .i_byte_sof   (ser_byte_sof),
        .i_byte_eof   (ser_byte_eof),
        .o_byte_take  (byte_take),
        .o_gmii_data  (o_gmii_data),
        .o_gmii_wr    (o_gmii_wr),
        .o_opc_state  (o_opc_state)
    );

endmodule

//--- dv/tb_output_control.sv
/*
 * Testbench for the packet output path. Packet cases come from a data
 * file, payloads from an LFSR; the GMII bytes, frame markers, gaps, finish
 * pulses and read request are checked against values built here.
 */

`timescale 1ns/1ns

`include "opc_params.svh"

module tb_output_control
    import opc_word_pkg::*;
    import opc_gmii_pkg::*;
();

    localparam int MAX_CASES = 64;
    localparam int PRE       = `OPC_PREAMBLE_LEN;

    logic              clk = 1'b0;
    logic              rst_n;
    opc_word_t         pkt_data;
    logic              pkt_data_wr;
    logic              pkt_rd_req;
    logic              pkt_tx_finish;
    opc_gmii_byte_t    gmii_data;
    logic              gmii_wr;
    opc_state_t        opc_state;

    logic [15:0]       case_mem [0:3*MAX_CASES-1];   // id, length, idle per case
    int                num_cases = 0;
    logic [31:0]       lfsr;
    logic              drv_last;                     // word on the bus ends its packet

    logic [7:0]        exp_bytes [$];
    int                exp_len [$];
    int                exp_id [$];

    // monitor state
    int                errors = 0;
    int                frames_done = 0;
    int                finish_cnt = 0;
    int                rd_req_drops = 0;
    int                words_held = 0;               // words stored in the DUT buffer
    int                frame_pos = 0;
    int                frame_len = 0;
    int                frame_id = 0;
    int                frame_err0 = 0;
    int                gap_low = 0;
    logic              in_frame = 1'b0;
    logic              seen_frame = 1'b0;
    logic              rd_req_low = 1'b0;
    logic              wr_pending = 1'b0;
    logic              word_popped = 1'b0;

    always #10 clk = ~clk;   // 20 ns period

    output_control i_output_control (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_pkt_data      (pkt_data),
        .i_pkt_data_wr   (pkt_data_wr),
        .o_pkt_rd_req    (pkt_rd_req),
        .o_pkt_tx_finish (pkt_tx_finish),
        .o_gmii_data     (gmii_data),
        .o_gmii_wr       (gmii_wr),
        .o_opc_state     (opc_state)
    );

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_byte(output logic [7:0] b);
        b = '0;
        for (int k = 0; k < 8; k++) begin
            b    = {b[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic send_packet(input int id, input int len);
        int            n_words;
        opc_word_t     w;
        logic [7:0]    b;
        n_words = (len + `OPC_WORD_BYTES - 1) / `OPC_WORD_BYTES;
        exp_id.push_back(id);
        exp_len.push_back(len);
        for (int wi = 0; wi < n_words; wi++) begin
            w = '0;
            for (int j = 0; j < `OPC_WORD_BYTES; j++) begin
                if (wi * `OPC_WORD_BYTES + j < len) begin
                    take_byte(b);
                    exp_bytes.push_back(b);
                    w.data[(`OPC_WORD_BYTES - 1 - j) * 8 +: 8] = b;   // msb first
                end
            end
            w.flag = opc_flag_t'({wi == n_words - 1, wi == 0});
            if (wi == n_words - 1) begin
                w.inval = opc_inval_t'(n_words * `OPC_WORD_BYTES - len);
            end
            // the request seen between edges already counts the previous write
            @(negedge clk);
            while (!pkt_rd_req) begin
                @(negedge clk);
            end
            @(posedge clk);
            pkt_data    <= w;
            pkt_data_wr <= 1'b1;
            drv_last    <= (wi == n_words - 1);
            @(posedge clk);
            pkt_data_wr <= 1'b0;
            drv_last    <= 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // monitor
    //////////////////////////////////////////////////////////////////////

    task automatic check_gmii_byte();
        logic [7:0]    exp_b;
        logic          exp_m;
        opc_state_t    exp_st;
        if (!in_frame) begin
            if (exp_len.size() == 0) begin
                errors++;
                $display("frame byte seen at %0t with no packet sent", $time);
                return;
            end
            frame_err0 = errors;
            if (seen_frame && gap_low < `OPC_IFG_CYCLES) begin
                errors++;
                $display("ERR @%0t: only %0d idle cycles before frame", $time, gap_low);
            end
            in_frame   = 1'b1;
            seen_frame = 1'b1;
            frame_pos  = 0;
            frame_id   = exp_id.pop_front();
            frame_len  = exp_len.pop_front();
        end
        if (frame_pos < PRE) begin
            exp_b  = (frame_pos == PRE - 1) ? `OPC_SFD_BYTE : `OPC_PREAMBLE_BYTE;
            exp_m  = (frame_pos == 0);
            exp_st = OPC_ST_PREAMBLE;
        end else begin
            exp_b  = exp_bytes.pop_front();
            exp_m  = (frame_pos - PRE == frame_len - 1);   // last data byte
            exp_st = OPC_ST_DATA;
            // the last valid byte of a word frees its buffer slot
            if ((frame_pos - PRE) % `OPC_WORD_BYTES == `OPC_WORD_BYTES - 1 || exp_m) begin
                word_popped = 1'b1;
            end
        end
        if (gmii_data.data !== exp_b || gmii_data.marker !== exp_m || opc_state !== exp_st) begin
            errors++;
            $display("ERR @%0t: case %0d byte %0d got %0b/%02h st %0d, exp %0b/%02h st %0d",
                     $time, frame_id, frame_pos, gmii_data.marker, gmii_data.data,
                     opc_state, exp_m, exp_b, exp_st);
        end
        frame_pos++;
        if (frame_pos == PRE + frame_len) begin
            in_frame = 1'b0;
            gap_low  = 0;
            frames_done++;
            if (errors == frame_err0) begin
                $display("case %0d, %0d bytes: ok", frame_id, frame_len);
            end else begin
                $display("case %0d, %0d bytes: %0d errors", frame_id, frame_len,
                         errors - frame_err0);
            end
        end
    endtask

    // sampled mid-cycle between driving edges
    always @(negedge clk) begin
        if (rst_n) begin
            if (pkt_tx_finish !== (pkt_data_wr && drv_last)) begin
                errors++;
                $display("ERR @%0t: tx_finish %0b, write %0b last %0b", $time,
                         pkt_tx_finish, pkt_data_wr, drv_last);
            end
            if (pkt_tx_finish) begin
                finish_cnt++;
            end
            word_popped = 1'b0;
            if (gmii_wr) begin
                check_gmii_byte();
            end else if (!in_frame) begin
                gap_low++;
            end
            // fill after the last edge, from the strobe seen before it and any pop
            if (wr_pending) begin
                words_held++;
            end
            if (word_popped) begin
                words_held--;
            end
            wr_pending = pkt_data_wr;
            if (pkt_rd_req !== (words_held < 2)) begin
                errors++;
                $display("ERR @%0t: rd_req %0b with %0d words held", $time,
                         pkt_rd_req, words_held);
            end
            if (!pkt_rd_req && !rd_req_low) begin
                rd_req_drops++;
            end
            rd_req_low = !pkt_rd_req;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // run control
    //////////////////////////////////////////////////////////////////////

    task automatic stop_on_timeout(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("timeout after %0d cycles: %0d of %0d frames seen", cycles,
                 frames_done, num_cases);
        $display("Result: FAILED");
        $finish;
    endtask

    initial begin
        int    limit;
        int    run_errors;
        int    len;
        run_errors  = 0;
        rst_n       = 1'b0;
        pkt_data    = '0;
        pkt_data_wr = 1'b0;
        drv_last    = 1'b0;
        lfsr        = 32'hb868_a40f;
        for (int i = 0; i < 3 * MAX_CASES; i++) begin
            case_mem[i] = '0;
        end
        $readmemh("dv/opc_cases.txt", case_mem);
        limit = 1000;
        while (num_cases < MAX_CASES && int'(case_mem[3 * num_cases + 1]) != 0) begin
            len   = int'(case_mem[3 * num_cases + 1]);
            limit = limit + 4 * (len + int'(case_mem[3 * num_cases + 2]));
            num_cases++;
        end
        fork
            stop_on_timeout(limit);
        join_none

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (gmii_wr !== 1'b0 || opc_state !== OPC_ST_IDLE || pkt_rd_req !== 1'b1) begin
            run_errors++;
            $display("ERR @%0t: after reset wr %0b state %0d rd_req %0b", $time,
                     gmii_wr, opc_state, pkt_rd_req);
        end

        for (int c = 0; c < num_cases; c++) begin
            repeat (int'(case_mem[3 * c + 2])) @(posedge clk);
            send_packet(int'(case_mem[3 * c]), int'(case_mem[3 * c + 1]));
        end
        wait (frames_done == num_cases);
        repeat (`OPC_IFG_CYCLES + 2) @(posedge clk);

        if (finish_cnt != num_cases) begin
            run_errors++;
            $display("ERR @%0t: %0d finish pulses for %0d packets", $time,
                     finish_cnt, num_cases);
        end
        if (rd_req_drops == 0) begin
            run_errors++;
            $display("read request never dropped, back-pressure was not exercised");
        end
        $display("summary: %0d cases, %0d frames, %0d finish pulses, %0d errors",
                 num_cases, frames_done, finish_cnt, errors + run_errors);
        if (errors + run_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- dv/opc_cases.txt
// packet cases, all values hex, one packet per line
// columns: case id, packet length in bytes (01..40), idle cycles before the packet
01 01 00
02 10 00
03 11 00
04 40 00
05 0f 03
06 20 00
07 21 00
08 02 05
09 3f 00
0a 30 00
0b 1f 02
0c 08 00
0d 2e 00
0e 01 00
0f 01 00
10 12 0a
11 40 00
12 40 00
13 0e 00
14 22 01
15 03 00
16 31 00
17 10 14
18 2f 00
19 05 00
1a 3e 00
1b 18 00
1c 27 06
1d 01 00
1e 40 00
1f 0d 00
20 3c 00
21 1e 00
22 21 04
23 07 00
24 2d 00
25 11 00

//--- sim.f
+incdir+common
common/opc_word_pkg.sv
common/opc_gmii_pkg.sv
word_buffer/opc_word_buffer.sv
byte_serializer/opc_byte_serializer.sv
gmii_framer/opc_gmii_framer.sv
src/output_control.sv
dv/tb_output_control.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the output_control testbench with Verilator and run it.
# The run counts as passed only if the log holds the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f sim.f --top-module tb_output_control -o tb_output_control

./obj_dir/tb_output_control | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
    echo "simulation run passed"
else
    echo "simulation run failed"
    exit 1
fi
